// ==== src/MipsPkg.sv ====
package MipsPkg;

    localparam int RegCount = 32;
    localparam logic [31:0] NopWord = 32'h0000_0000;

    // ************************************************************************
    // Instruction encodings
    // ************************************************************************

    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpJ       = 6'h02,
        OpBeq     = 6'h04,
        OpBne     = 6'h05,
        OpAddiu   = 6'h09,
        OpOri     = 6'h0d,
        OpLui     = 6'h0f,
        OpLb      = 6'h20,
        OpLw      = 6'h23,
        OpLbu     = 6'h24,
        OpSb      = 6'h28,
        OpSw      = 6'h2b
    } OpcodeT;

    typedef enum logic [5:0] {
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnSlt  = 6'h2a
    } FunctT;

    typedef struct packed {
        OpcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        FunctT       funct;
    } RTypeT;

    typedef struct packed {
        OpcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } ITypeT;

    typedef struct packed {
        OpcodeT      opcode;
        logic [25:0] target;
    } JTypeT;

    // One instruction word viewed in whichever format the opcode calls for
    typedef union packed {
        RTypeT r;
        ITypeT i;
        JTypeT j;
    } InstrT;

    // ************************************************************************
    // Control encodings
    // ************************************************************************

    // Add is the zero encoding so a cleared stage register is a no-op
    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluSlt = 3'd4,
        AluLui = 3'd5
    } AluOpT;

    typedef enum logic [1:0] {
        MemWord  = 2'd0,
        MemByte  = 2'd1,
        MemByteU = 2'd2
    } MemModeT;

    typedef enum logic [1:0] {
        FwdReg = 2'd0,
        FwdMem = 2'd1,
        FwdWb  = 2'd2
    } FwdSelT;

    // ************************************************************************
    // Pipeline registers
    // ************************************************************************

    typedef struct packed {
        InstrT       instr;
        logic [31:0] pcPlus4;
    } FetchOutT;

    typedef struct packed {
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] imm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        AluOpT       aluOp;
        logic        useImm;
        logic        memRead;
        logic        memWrite;
        MemModeT     memMode;
        logic        regWrite;
    } DecodeOutT;

    typedef struct packed {
        logic [31:0] aluResult;
        logic [31:0] storeData;
        logic [4:0]  dest;
        logic        memRead;
        logic        memWrite;
        MemModeT     memMode;
        logic        regWrite;
    } ExecuteOutT;

    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  dest;
        logic        regWrite;
    } WriteBackT;

endpackage

// ==== src/Fetch.sv ====
`timescale 1ns/100ps

module Fetch import MipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    output logic [31:0] instrAddr,
    input  logic [31:0] instrRead,
    output FetchOutT    fetchOut
);

    logic [31:0] pc;
    logic [31:0] pcPlus4;

    assign pcPlus4 = pc + 32'd4;
    assign instrAddr = pc;

    // Branch target arrives while the delay slot is being fetched
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            fetchOut.instr <= NopWord;
            fetchOut.pcPlus4 <= '0;
        end else if (!stall) begin
            pc <= branchTaken ? branchTarget : pcPlus4;
            fetchOut.instr <= instrRead;
            fetchOut.pcPlus4 <= pcPlus4;
        end
    end

endmodule

// ==== src/Decode.sv ====
`timescale 1ns/100ps

module Decode import MipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        bubble,
    input  FetchOutT    fetchOut,
    input  WriteBackT   writeBack,
    input  logic [31:0] memResult,
    input  logic        branchFwdA,
    input  logic        branchFwdB,
    output logic        branchTaken,
    output logic [31:0] branchTarget,
    output logic        branchUse,
    output logic [4:0]  decodeRs,
    output logic [4:0]  decodeRt,
    output DecodeOutT   decodeOut
);

    InstrT       instr;
    logic [31:0] regs [RegCount];
    logic [31:0] rsValue;
    logic [31:0] rtValue;
    logic [31:0] cmpA;
    logic [31:0] cmpB;
    logic [31:0] signImm;
    logic [31:0] zeroImm;
    DecodeOutT   decoded;

    assign instr = fetchOut.instr;
    assign decodeRs = instr.r.rs;
    assign decodeRt = instr.r.rt;

    // ************************************************************************
    // Register file
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (writeBack.regWrite && writeBack.dest != 5'd0) begin
            regs[writeBack.dest] <= writeBack.result;
        end
    end

    // Write-first so the value being written back is visible in the same cycle
    assign rsValue = (instr.r.rs == 5'd0) ? '0 :
                     (writeBack.regWrite && writeBack.dest == instr.r.rs) ?
                     writeBack.result : regs[instr.r.rs];
    assign rtValue = (instr.r.rt == 5'd0) ? '0 :
                     (writeBack.regWrite && writeBack.dest == instr.r.rt) ?
                     writeBack.result : regs[instr.r.rt];

    assign cmpA = branchFwdA ? memResult : rsValue;
    assign cmpB = branchFwdB ? memResult : rtValue;

    assign signImm = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign zeroImm = {16'h0000, instr.i.imm};

    // ************************************************************************
    // Control decode and branch resolution
    // ************************************************************************

    always_comb begin
        decoded = '0;
        decoded.opA = rsValue;
        decoded.opB = rtValue;
        decoded.imm = signImm;
        decoded.rs = instr.r.rs;
        decoded.rt = instr.r.rt;
        branchTaken = 1'b0;
        branchUse = 1'b0;
        branchTarget = fetchOut.pcPlus4 + {signImm[29:0], 2'b00};

        case (instr.r.opcode)
            OpSpecial: begin
                decoded.dest = instr.r.rd;
                decoded.regWrite = 1'b1;
                case (instr.r.funct)
                    FnAddu:  decoded.aluOp = AluAdd;
                    FnSubu:  decoded.aluOp = AluSub;
                    FnAnd:   decoded.aluOp = AluAnd;
                    FnOr:    decoded.aluOp = AluOr;
                    FnSlt:   decoded.aluOp = AluSlt;
                    // Unsupported functions (and the all-zero no-op) write nothing
                    default: decoded.regWrite = 1'b0;
                endcase
            end
            OpAddiu, OpOri, OpLui: begin
                decoded.dest = instr.i.rt;
                decoded.regWrite = 1'b1;
                decoded.useImm = 1'b1;
                if (instr.i.opcode == OpOri) begin
                    decoded.imm = zeroImm;
                    decoded.aluOp = AluOr;
                end else if (instr.i.opcode == OpLui) begin
                    decoded.imm = zeroImm;
                    decoded.aluOp = AluLui;
                end
            end
            OpLw, OpLb, OpLbu: begin
                decoded.dest = instr.i.rt;
                decoded.regWrite = 1'b1;
                decoded.useImm = 1'b1;
                decoded.memRead = 1'b1;
                if (instr.i.opcode == OpLb) begin
                    decoded.memMode = MemByte;
                end else if (instr.i.opcode == OpLbu) begin
                    decoded.memMode = MemByteU;
                end
            end
            OpSw, OpSb: begin
                decoded.useImm = 1'b1;
                decoded.memWrite = 1'b1;
                decoded.memMode = (instr.i.opcode == OpSb) ? MemByte : MemWord;
            end
            OpBeq: begin
                branchUse = 1'b1;
                branchTaken = (cmpA == cmpB);
            end
            OpBne: begin
                branchUse = 1'b1;
                branchTaken = (cmpA != cmpB);
            end
            OpJ: begin
                branchTaken = 1'b1;
                branchTarget = {fetchOut.pcPlus4[31:28], instr.j.target, 2'b00};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decodeOut <= '0;
        end else if (bubble) begin
            decodeOut <= '0;
        end else begin
            decodeOut <= decoded;
        end
    end

endmodule

// ==== src/Execute.sv ====
`timescale 1ns/100ps

module Execute import MipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  DecodeOutT   decodeOut,
    input  FwdSelT      fwdA,
    input  FwdSelT      fwdB,
    input  logic [31:0] memResult,
    input  WriteBackT   writeBack,
    output ExecuteOutT  executeOut
);

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] aluB;
    logic [31:0] aluResult;

    function automatic logic [31:0] pickOperand(input FwdSelT sel,
                                                input logic [31:0] regValue,
                                                input logic [31:0] memValue,
                                                input logic [31:0] wbValue);
        case (sel)
            FwdMem:  return memValue;
            FwdWb:   return wbValue;
            default: return regValue;
        endcase
    endfunction

    assign srcA = pickOperand(fwdA, decodeOut.opA, memResult, writeBack.result);
    assign srcB = pickOperand(fwdB, decodeOut.opB, memResult, writeBack.result);
    assign aluB = decodeOut.useImm ? decodeOut.imm : srcB;

    always_comb begin
        case (decodeOut.aluOp)
            AluSub:  aluResult = srcA - aluB;
            AluAnd:  aluResult = srcA & aluB;
            AluOr:   aluResult = srcA | aluB;
            AluSlt:  aluResult = {31'b0, $signed(srcA) < $signed(aluB)};
            AluLui:  aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = srcA + aluB;
        endcase
    end

    // Store data is register B after forwarding and never the immediate
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            executeOut <= '0;
        end else begin
            executeOut.aluResult <= aluResult;
            executeOut.storeData <= srcB;
            executeOut.dest <= decodeOut.dest;
            executeOut.memRead <= decodeOut.memRead;
            executeOut.memWrite <= decodeOut.memWrite;
            executeOut.memMode <= decodeOut.memMode;
            executeOut.regWrite <= decodeOut.regWrite;
        end
    end

endmodule

// ==== src/Memory.sv ====
`timescale 1ns/100ps

module Memory import MipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  ExecuteOutT  executeOut,
    output logic        dataEn,
    output logic        dataWriteEn,
    output MemModeT     dataMode,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWrite,
    input  logic [31:0] dataRead,
    output WriteBackT   writeBack
);

    logic [7:0]  loadByte;
    logic [31:0] loadValue;
    logic [31:0] result;

    assign dataEn = executeOut.memRead | executeOut.memWrite;
    assign dataWriteEn = executeOut.memWrite;
    assign dataMode = executeOut.memMode;
    assign dataAddr = executeOut.aluResult;

    // Byte stores go out on every lane and memory picks the lane from dataAddr[1:0]
    assign dataWrite = (executeOut.memMode == MemWord) ? executeOut.storeData :
                       {4{executeOut.storeData[7:0]}};

    // Lane 0 is the least significant byte
    assign loadByte = dataRead[8*executeOut.aluResult[1:0] +: 8];

    always_comb begin
        case (executeOut.memMode)
            MemByte:  loadValue = {{24{loadByte[7]}}, loadByte};
            MemByteU: loadValue = {24'h000000, loadByte};
            default:  loadValue = dataRead;
        endcase
    end

    assign result = executeOut.memRead ? loadValue : executeOut.aluResult;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            writeBack <= '0;
        end else begin
            writeBack.result <= result;
            writeBack.dest <= executeOut.dest;
            writeBack.regWrite <= executeOut.regWrite;
        end
    end

endmodule

// ==== src/Hazard.sv ====
`timescale 1ns/100ps

module Hazard import MipsPkg::*; (
    input  logic [4:0]  decodeRs,
    input  logic [4:0]  decodeRt,
    input  logic        branchUse,
    input  DecodeOutT   decodeOut,
    input  ExecuteOutT  executeOut,
    input  WriteBackT   writeBack,
    output logic        stall,
    output logic        bubble,
    output FwdSelT      fwdA,
    output FwdSelT      fwdB,
    output logic        branchFwdA,
    output logic        branchFwdB
);

    logic loadUse;
    logic branchOnExec;
    logic branchOnLoad;

    function automatic logic hits(input logic [4:0] src,
                                  input logic [4:0] dst,
                                  input logic writes);
        return writes && dst != 5'd0 && dst == src;
    endfunction

    // Memory stage is newer than writeback, so it is checked first
    assign fwdA = hits(decodeOut.rs, executeOut.dest, executeOut.regWrite) ? FwdMem :
                  hits(decodeOut.rs, writeBack.dest, writeBack.regWrite) ? FwdWb : FwdReg;
    assign fwdB = hits(decodeOut.rt, executeOut.dest, executeOut.regWrite) ? FwdMem :
                  hits(decodeOut.rt, writeBack.dest, writeBack.regWrite) ? FwdWb : FwdReg;

    assign branchFwdA = hits(decodeRs, executeOut.dest, executeOut.regWrite);
    assign branchFwdB = hits(decodeRt, executeOut.dest, executeOut.regWrite);

    assign loadUse = hits(decodeRs, decodeOut.dest, decodeOut.memRead) |
                     hits(decodeRt, decodeOut.dest, decodeOut.memRead);

    // Branch operands are needed a stage earlier than ALU operands
    assign branchOnExec = branchUse & (hits(decodeRs, decodeOut.dest, decodeOut.regWrite) |
                                       hits(decodeRt, decodeOut.dest, decodeOut.regWrite));
    assign branchOnLoad = branchUse & (hits(decodeRs, executeOut.dest, executeOut.memRead) |
                                       hits(decodeRt, executeOut.dest, executeOut.memRead));

    assign stall = loadUse | branchOnExec | branchOnLoad;
    assign bubble = stall;

endmodule

// ==== src/Datapath.sv ====
`timescale 1ns/100ps

module Datapath import MipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    output logic [31:0] instrAddr,
    input  logic [31:0] instrRead,
    output logic        dataEn,
    output logic        dataWriteEn,
    output MemModeT     dataMode,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWrite,
    input  logic [31:0] dataRead
);

    FetchOutT    fetchOut;
    DecodeOutT   decodeOut;
    ExecuteOutT  executeOut;
    WriteBackT   writeBack;
    logic        stall;
    logic        bubble;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic        branchUse;
    logic [4:0]  decodeRs;
    logic [4:0]  decodeRt;
    FwdSelT      fwdA;
    FwdSelT      fwdB;
    logic        branchFwdA;
    logic        branchFwdB;

    Fetch Fetch_i (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .instrAddr    (instrAddr),
        .instrRead    (instrRead),
        .fetchOut     (fetchOut)
    );

    // Writeback register from Memory feeds the register file write port
    Decode Decode_i (
        .clk          (clk),
        .rstN         (rstN),
        .bubble       (bubble),
        .fetchOut     (fetchOut),
        .writeBack    (writeBack),
        .memResult    (executeOut.aluResult),
        .branchFwdA   (branchFwdA),
        .branchFwdB   (branchFwdB),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .branchUse    (branchUse),
        .decodeRs     (decodeRs),
        .decodeRt     (decodeRt),
        .decodeOut    (decodeOut)
    );

    Execute Execute_i (
        .clk        (clk),
        .rstN       (rstN),
        .decodeOut  (decodeOut),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .memResult  (executeOut.aluResult),
        .writeBack  (writeBack),
        .executeOut (executeOut)
    );

    Memory Memory_i (
        .clk         (clk),
        .rstN        (rstN),
        .executeOut  (executeOut),
        .dataEn      (dataEn),
        .dataWriteEn (dataWriteEn),
        .dataMode    (dataMode),
        .dataAddr    (dataAddr),
        .dataWrite   (dataWrite),
        .dataRead    (dataRead),
        .writeBack   (writeBack)
    );

    Hazard Hazard_i (
        .decodeRs   (decodeRs),
        .decodeRt   (decodeRt),
        .branchUse  (branchUse),
        .decodeOut  (decodeOut),
        .executeOut (executeOut),
        .writeBack  (writeBack),
        .stall      (stall),
        .bubble     (bubble),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .branchFwdA (branchFwdA),
        .branchFwdB (branchFwdB)
    );

endmodule

// ==== verification/MemoryModel.sv ====
`timescale 1ns/100ps

module MemoryModel import MipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] instrAddr,
    output logic [31:0] instrRead,
    input  logic        dataEn,
    input  logic        dataWriteEn,
    input  MemModeT     dataMode,
    input  logic [31:0] dataAddr,
    input  logic [31:0] dataWrite,
    output logic [31:0] dataRead
);

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic [7:0]  ramIndex;
    logic [1:0]  lane;

    assign instrRead = rom[instrAddr[9:2]];
    assign ramIndex = dataAddr[9:2];
    assign lane = dataAddr[1:0];
    assign dataRead = ram[ramIndex];

    // RAM clears with the DUT reset so each program starts from zeros
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= '0;
            end
        end else if (dataEn && dataWriteEn) begin
            if (dataMode == MemWord) begin
                ram[ramIndex] <= dataWrite;
            end else begin
                ram[ramIndex][8*lane +: 8] <= dataWrite[8*lane +: 8];
            end
        end
    end

    task automatic loadRom(input int index, input logic [31:0] word);
        rom[8'(index)] = word;
    endtask

    function automatic logic [31:0] ramWord(input logic [31:0] addr);
        return ram[addr[9:2]];
    endfunction

endmodule

// ==== verification/DatapathTb.sv ====
`timescale 1ns/100ps

module DatapathTb import MipsPkg::*; ();

    logic        clk = 1'b0;
    logic        rstN;
    logic [31:0] instrAddr;
    logic [31:0] instrRead;
    logic        dataEn;
    logic        dataWriteEn;
    MemModeT     dataMode;
    logic [31:0] dataAddr;
    logic [31:0] dataWrite;
    logic [31:0] dataRead;

    logic [31:0] prog [256];
    int          progLen;
    int          errorCount;
    int          testCount;
    int          failedTests;
    int          firstData;
    int          endCycle;
    logic        finished;

    always #2 clk = ~clk;

    Datapath Datapath_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrAddr   (instrAddr),
        .instrRead   (instrRead),
        .dataEn      (dataEn),
        .dataWriteEn (dataWriteEn),
        .dataMode    (dataMode),
        .dataAddr    (dataAddr),
        .dataWrite   (dataWrite),
        .dataRead    (dataRead)
    );

    MemoryModel MemoryModel_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrAddr   (instrAddr),
        .instrRead   (instrRead),
        .dataEn      (dataEn),
        .dataWriteEn (dataWriteEn),
        .dataMode    (dataMode),
        .dataAddr    (dataAddr),
        .dataWrite   (dataWrite),
        .dataRead    (dataRead)
    );

    // ************************************************************************
    // Program assembly
    // ************************************************************************

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic opR(input FunctT fn, input int rd, input int rs, input int rt);
        emit({OpSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn});
    endtask

    // Operands go in assembly order rt, rs, immediate
    // Loads and stores use rs as the base
    task automatic opI(input OpcodeT op, input int rt, input int rs, input logic [15:0] imm);
        emit({op, 5'(rs), 5'(rt), imm});
    endtask

    task automatic opB(input OpcodeT op, input int rs, input int rt, input logic [15:0] off);
        emit({op, 5'(rs), 5'(rt), off});
    endtask

    task automatic opJ(input int index);
        emit({OpJ, 26'(index)});
    endtask

    task automatic loadWord(input int r, input logic [31:0] value);
        opI(OpLui, r, 0, value[31:16]);
        opI(OpOri, r, r, value[15:0]);
    endtask

    task automatic endProgram();
        opI(OpSw, 0, 0, 16'h03FC);
    endtask

    // ************************************************************************
    // Run control and checking
    // ************************************************************************

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string testName, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("[%s] passed", testName);
        end else begin
            failedTests++;
            $display("[%s] failed with %0d errors", testName, errorCount - startErrors);
        end
    endtask

    task automatic runProgram(input string testName);
        int   cycles;
        logic resetFault;
        cycles = 0;
        resetFault = 1'b0;
        firstData = -1;
        finished = 1'b0;
        @(negedge clk);
        rstN = 1'b0;
        for (int i = 0; i < 256; i++) begin
            MemoryModel_i.loadRom(i, (i < progLen) ? prog[i] : NopWord);
        end
        repeat (5) begin
            @(negedge clk);
            if (instrAddr != 32'd0 || dataEn || dataWriteEn) begin
                resetFault = 1'b1;
            end
        end
        rstN = 1'b1;
        if (resetFault) begin
            $display("%s: PC or data strobes were not idle during reset", testName);
            errorCount++;
        end
        while (!finished && cycles < 500) begin
            @(negedge clk);
            cycles++;
            if ((dataEn || dataWriteEn) && firstData < 0) begin
                firstData = cycles;
            end
            if (dataEn && dataWriteEn && dataMode == MemWord && dataAddr == 32'h0000_03FC) begin
                finished = 1'b1;
                endCycle = cycles;
            end
        end
        if (!finished) begin
            $display("%s: timeout, the program did not reach its final store in 500 cycles",
                     testName);
            errorCount++;
        end
    endtask

    // ************************************************************************
    // Directed tests
    // ************************************************************************

    task automatic testReset();
        int startErrors;
        startErrors = errorCount;
        progLen = 0;
        opI(OpOri, 1, 0, 16'd1);
        opI(OpOri, 2, 0, 16'd2);
        opR(FnAddu, 3, 1, 2);
        emit(NopWord);
        opI(OpSw, 3, 0, 16'h0300);
        endProgram();
        runProgram("reset");
        if (finished) begin
            // Word 4 reaches Memory after 7 rising edges
            checkValue("reset", 32'd7, 32'(firstData));
            checkValue("reset", 32'd8, 32'(endCycle));
            checkValue("reset", 32'd3, MemoryModel_i.ramWord(32'h300));
        end
        reportTest("reset", startErrors);
    endtask

    task automatic testAluChain();
        int          startErrors;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [31:0] sum;
        logic [31:0] diff;
        logic [31:0] andValue;
        logic [31:0] orValue;
        logic [31:0] sltValue;
        logic [31:0] addiValue;
        startErrors = errorCount;
        a = $urandom();
        b = $urandom();
        imm = 16'($urandom());
        sum = a + b;
        diff = sum - a;
        andValue = diff & sum;
        orValue = andValue | a;
        sltValue = ($signed(orValue) < $signed(diff)) ? 32'd1 : 32'd0;
        addiValue = sltValue + {{16{imm[15]}}, imm};
        progLen = 0;
        loadWord(1, a);
        loadWord(2, b);
        opR(FnAddu, 3, 1, 2);
        opR(FnSubu, 4, 3, 1);
        opR(FnAnd, 5, 4, 3);
        opR(FnOr, 6, 5, 1);
        opR(FnSlt, 7, 6, 4);
        opI(OpAddiu, 8, 7, imm);
        opI(OpSw, 8, 0, 16'h0014);
        opI(OpSw, 1, 0, 16'h0000);
        opI(OpSw, 3, 0, 16'h0004);
        opI(OpSw, 4, 0, 16'h0008);
        opI(OpSw, 5, 0, 16'h000C);
        opI(OpSw, 6, 0, 16'h0010);
        opI(OpSw, 7, 0, 16'h0018);
        endProgram();
        runProgram("alu chain");
        if (finished) begin
            checkValue("alu chain", a, MemoryModel_i.ramWord(32'h00));
            checkValue("alu chain", sum, MemoryModel_i.ramWord(32'h04));
            checkValue("alu chain", diff, MemoryModel_i.ramWord(32'h08));
            checkValue("alu chain", andValue, MemoryModel_i.ramWord(32'h0C));
            checkValue("alu chain", orValue, MemoryModel_i.ramWord(32'h10));
            checkValue("alu chain", addiValue, MemoryModel_i.ramWord(32'h14));
            checkValue("alu chain", sltValue, MemoryModel_i.ramWord(32'h18));
        end
        reportTest("alu chain", startErrors);
    endtask

    task automatic testLoadUse();
        int          startErrors;
        logic [31:0] x;
        logic [31:0] y;
        startErrors = errorCount;
        x = $urandom();
        y = $urandom();
        progLen = 0;
        loadWord(1, x);
        loadWord(5, y);
        opI(OpSw, 1, 0, 16'h0040);
        opI(OpLw, 2, 0, 16'h0040);
        opR(FnAddu, 3, 2, 5);
        opI(OpSw, 3, 0, 16'h0044);
        opI(OpLw, 4, 0, 16'h0044);
        opI(OpSw, 4, 0, 16'h0048);
        endProgram();
        runProgram("load use");
        if (finished) begin
            checkValue("load use", x, MemoryModel_i.ramWord(32'h40));
            checkValue("load use", x + y, MemoryModel_i.ramWord(32'h44));
            checkValue("load use", x + y, MemoryModel_i.ramWord(32'h48));
        end
        reportTest("load use", startErrors);
    endtask

    task automatic testByteAccess();
        int          startErrors;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [7:0]  b3;
        logic [31:0] w;
        logic [31:0] merged;
        startErrors = errorCount;
        b0 = 8'($urandom()) | 8'h80;
        b1 = 8'($urandom()) | 8'h80;
        b2 = 8'($urandom()) | 8'h80;
        b3 = 8'($urandom()) | 8'h80;
        w = $urandom();
        merged = {w[31:24], b0, w[15:0]};
        progLen = 0;
        // Upper register bits must not leak into memory
        opI(OpOri, 1, 0, {8'hC3, b0});
        opI(OpOri, 2, 0, {8'hC3, b1});
        opI(OpOri, 3, 0, {8'hC3, b2});
        opI(OpOri, 4, 0, {8'hC3, b3});
        opI(OpSb, 1, 0, 16'h0080);
        opI(OpSb, 2, 0, 16'h0081);
        opI(OpSb, 3, 0, 16'h0082);
        opI(OpSb, 4, 0, 16'h0083);
        loadWord(9, w);
        opI(OpSw, 9, 0, 16'h00A0);
        opI(OpSb, 1, 0, 16'h00A2);
        opI(OpLb, 5, 0, 16'h0081);
        opI(OpSw, 5, 0, 16'h0090);
        opI(OpLbu, 6, 0, 16'h0082);
        opI(OpSw, 6, 0, 16'h0094);
        opI(OpLb, 7, 0, 16'h0083);
        opI(OpSw, 7, 0, 16'h0098);
        opI(OpLw, 10, 0, 16'h00A0);
        opI(OpSw, 10, 0, 16'h009C);
        endProgram();
        runProgram("byte access");
        if (finished) begin
            checkValue("byte access", {b3, b2, b1, b0}, MemoryModel_i.ramWord(32'h80));
            checkValue("byte access", merged, MemoryModel_i.ramWord(32'hA0));
            checkValue("byte access", {{24{b1[7]}}, b1}, MemoryModel_i.ramWord(32'h90));
            checkValue("byte access", {24'h000000, b2}, MemoryModel_i.ramWord(32'h94));
            checkValue("byte access", {{24{b3[7]}}, b3}, MemoryModel_i.ramWord(32'h98));
            checkValue("byte access", merged, MemoryModel_i.ramWord(32'h9C));
        end
        reportTest("byte access", startErrors);
    endtask

    task automatic testBranches();
        int          startErrors;
        logic [31:0] expected [12];
        startErrors = errorCount;
        // Zero marks a store that a taken branch must skip
        expected = '{32'd5, 32'd0, 32'd5, 32'd0, 32'd7, 32'd7,
                     32'd5, 32'd5, 32'd7, 32'd0, 32'd7, 32'd0};
        progLen = 0;
        opI(OpOri, 1, 0, 16'd5);
        opI(OpOri, 2, 0, 16'd5);
        opI(OpOri, 3, 0, 16'd7);
        opB(OpBeq, 1, 2, 16'd2);
        opI(OpSw, 1, 0, 16'h0100);
        opI(OpSw, 3, 0, 16'h0104);
        opB(OpBne, 1, 3, 16'd2);
        opI(OpSw, 2, 0, 16'h0108);
        opI(OpSw, 3, 0, 16'h010C);
        opB(OpBeq, 1, 3, 16'd2);
        opI(OpSw, 3, 0, 16'h0110);
        opI(OpSw, 3, 0, 16'h0114);
        opB(OpBne, 1, 2, 16'd2);
        opI(OpSw, 1, 0, 16'h0118);
        opI(OpSw, 1, 0, 16'h011C);
        opI(OpAddiu, 4, 1, 16'd2);
        opB(OpBeq, 4, 3, 16'd2);
        opI(OpSw, 4, 0, 16'h0120);
        opI(OpSw, 4, 0, 16'h0124);
        opI(OpLw, 5, 0, 16'h0120);
        opB(OpBne, 5, 1, 16'd2);
        opI(OpSw, 5, 0, 16'h0128);
        opI(OpSw, 5, 0, 16'h012C);
        endProgram();
        runProgram("branches");
        if (finished) begin
            for (int k = 0; k < 12; k++) begin
                checkValue("branches", expected[k],
                           MemoryModel_i.ramWord(32'h100 + 32'(k) * 32'd4));
            end
        end
        reportTest("branches", startErrors);
    endtask

    task automatic testJump();
        int          startErrors;
        logic [31:0] expected;
        startErrors = errorCount;
        progLen = 0;
        opI(OpOri, 1, 0, 16'h0011);
        opJ(6);
        opI(OpSw, 1, 0, 16'h0200);
        opI(OpSw, 1, 0, 16'h0204);
        opI(OpSw, 1, 0, 16'h0208);
        opI(OpSw, 1, 0, 16'h020C);
        opI(OpOri, 2, 0, 16'h0022);
        opI(OpSw, 2, 0, 16'h0210);
        endProgram();
        runProgram("jump");
        if (finished) begin
            for (int i = 0; i < 256; i++) begin
                expected = (i == 128) ? 32'h11 : (i == 132) ? 32'h22 : 32'h0;
                checkValue("jump", expected, MemoryModel_i.ramWord(32'(i) << 2));
            end
        end
        reportTest("jump", startErrors);
    endtask

    initial begin
        rstN = 1'b0;
        progLen = 0;
        errorCount = 0;
        testCount = 0;
        failedTests = 0;
        firstData = -1;
        endCycle = 0;
        finished = 1'b0;
        void'($urandom(76));
        testReset();
        testAluChain();
        testLoadUse();
        testByteAccess();
        testBranches();
        testJump();
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== mips.f ====
src/MipsPkg.sv
src/Fetch.sv
src/Decode.sv
src/Execute.sv
src/Memory.sv
src/Hazard.sv
src/Datapath.sv
verification/MemoryModel.sv
verification/DatapathTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module DatapathTb -f mips.f
./obj_dir/VDatapathTb | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1
